//--- vlog.f
+incdir+.
priv_pkg.sv
clic_pkg.sv
clic_cfg_regs.sv
clic_arbiter.sv
clic_irq_ctrl.sv
clic_top.sv
tb_clic.sv

//--- run.sh
#!/usr/bin/env bash
# Build the CLIC testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_clic

# A failing run exits nonzero, the verdict comes from the output text
sim_out=$(./obj_dir/Vtb_clic 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi

//--- tb_clic.sv
// CLIC testbench
// Drives register writes, source pulses and core acknowledges into the CLIC
// and checks every request against a model of the registers, the pending
// set and the privilege state

`include "clic_params.svh"

module tb_clic
  import priv_pkg::*;
  import clic_pkg::*;
();

  typedef logic [`CLIC_NUM_SRC-1:0] src_mask_t;

  localparam int MAX_CYCLES = 4000;  // about twice the test length
  localparam int REQ_WAIT   = 20;    // cycles allowed for a request to appear
  localparam int ROUNDS     = 16;    // random selection rounds

  // DUT connections
  logic       clk;
  logic       arst_n;
  logic       cfg_we;
  cfg_addr_t  cfg_addr;
  cfg_data_t  cfg_wdata;
  src_mask_t  irq_src;
  logic       irq_ack;
  logic       irq_req;
  irq_cause_t irq_cause;

  // Model state
  src_mask_t  en_m;
  irq_level_t lvl_m [`CLIC_NUM_SRC];
  priv_lvl_e  spriv_m [`CLIC_NUM_SRC];
  src_mask_t  pend_m;
  src_mask_t  src_prev;  // last driven source lines
  priv_lvl_e  priv_m;
  irq_level_t mthresh_m, sthresh_m, mil_m, sil_m;
  logic       sie_m;
  irq_id_t    ack_id;    // ID the testbench acknowledges

  // Derived from the model for the running request
  irq_id_t    req_id;
  irq_level_t eff_m, eff_s;
  logic       cause_ok, member_ok, accept_ok;

  integer seed;
  int     cycle_cnt = 0;

  clic_top i_dut (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .cfg_we_i   (cfg_we),
    .cfg_addr_i (cfg_addr),
    .cfg_wdata_i(cfg_wdata),
    .irq_src_i  (irq_src),
    .irq_ack_i  (irq_ack),
    .irq_req_o  (irq_req),
    .irq_cause_o(irq_cause)
  );

  always #4 clk = ~clk;

  // ----------------------------------------------------------
  // Failure reporting and run limit
  // ----------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout, tests did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // ----------------------------------------------------------
  // Reference model, tracks registers at the same clock edges
  // ----------------------------------------------------------
  always @(posedge clk or negedge arst_n) begin : model_update
    src_mask_t pend_next;
    if (!arst_n) begin
      en_m      <= '0;
      pend_m    <= '0;
      src_prev  <= '0;
      priv_m    <= PRIV_M;  // machine mode after reset
      mthresh_m <= '0;
      sthresh_m <= '0;
      mil_m     <= '0;
      sil_m     <= '0;
      sie_m     <= 1'b0;
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        lvl_m[i]   <= '0;
        spriv_m[i] <= PRIV_U;
      end
    end else begin
      pend_next = pend_m | (irq_src & ~src_prev);  // rising edges pend
      if (irq_ack) pend_next[ack_id] = 1'b0;
      pend_m   <= pend_next;
      src_prev <= irq_src;
      if (cfg_we) begin
        if (cfg_addr < cfg_addr_t'(`CLIC_NUM_SRC)) begin
          lvl_m[cfg_addr[`CLIC_ID_W-1:0]]   <= cfg_wdata[7:0];
          spriv_m[cfg_addr[`CLIC_ID_W-1:0]] <= priv_lvl_e'(cfg_wdata[9:8]);
          en_m[cfg_addr[`CLIC_ID_W-1:0]]    <= cfg_wdata[10];
        end
        case (cfg_addr)
          cfg_addr_t'(`CLIC_ADDR_MTHRESH): mthresh_m <= cfg_wdata[7:0];
          cfg_addr_t'(`CLIC_ADDR_STHRESH): sthresh_m <= cfg_wdata[7:0];
          cfg_addr_t'(`CLIC_ADDR_STATUS): begin
            mil_m <= cfg_wdata[7:0];
            sil_m <= cfg_wdata[15:8];
          end
          cfg_addr_t'(`CLIC_ADDR_PRIV): begin
            priv_m <= priv_lvl_e'(cfg_wdata[1:0]);
            sie_m  <= cfg_wdata[2];
          end
          default: ;
        endcase
      end
      // Taken interrupt moves privilege and status
      if (irq_ack) begin
        priv_m <= spriv_m[ack_id];
        if (spriv_m[ack_id] == PRIV_M) begin
          mil_m <= lvl_m[ack_id];
        end else if (spriv_m[ack_id] == PRIV_S) begin
          sil_m <= lvl_m[ack_id];
          sie_m <= 1'b0;
        end
      end
    end
  end

  function automatic irq_cause_t exp_cause(input irq_id_t id, input irq_level_t lvl);
    irq_cause_t c;
    c = '0;
    c[31] = 1'b1;  // interrupt flag
    c[23:16] = lvl;
    c[`CLIC_ID_W-1:0] = id;
    return c;
  endfunction

  always_comb begin
    req_id    = irq_cause[`CLIC_ID_W-1:0];
    cause_ok  = (irq_cause == exp_cause(req_id, lvl_m[req_id]));
    member_ok = pend_m[req_id] & en_m[req_id];
    eff_m     = (mthresh_m > mil_m) ? mthresh_m : mil_m;
    eff_s     = (sthresh_m > sil_m) ? sthresh_m : sil_m;
    case (priv_m)
      PRIV_M:  accept_ok = (spriv_m[req_id] == PRIV_M) && (lvl_m[req_id] > eff_m);
      PRIV_S:  accept_ok = (spriv_m[req_id] == PRIV_M)
                        || ((spriv_m[req_id] == PRIV_S) && sie_m && (lvl_m[req_id] > eff_s));
      PRIV_U:  accept_ok = 1'b1;
      default: accept_ok = 1'b0;
    endcase
  end

  // Checked on every cycle with a request
  a_cause: assert property (@(posedge clk) disable iff (!arst_n) irq_req |-> cause_ok)
    else report_mismatch("cause word differs from flag, level and ID of the source");
  a_member: assert property (@(posedge clk) disable iff (!arst_n) irq_req |-> member_ok)
    else report_mismatch("request from a source that is not pending and enabled");
  a_accept: assert property (@(posedge clk) disable iff (!arst_n) irq_req |-> accept_ok)
    else report_mismatch("request breaks the privilege and threshold rule");

  // ----------------------------------------------------------
  // Stimulus helpers, inputs change 1 unit after the edge
  // ----------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic write_reg(input int addr, input cfg_data_t data);
    cfg_we    = 1'b1;
    cfg_addr  = cfg_addr_t'(addr);
    cfg_wdata = data;
    tick();
    cfg_we    = 1'b0;
  endtask

  task automatic cfg_src(input irq_id_t id, input logic en, input priv_lvl_e p,
                         input irq_level_t lvl);
    write_reg(int'(id), cfg_data_t'({en, p, lvl}));
  endtask

  task automatic set_priv(input priv_lvl_e p, input logic sie);
    write_reg(`CLIC_ADDR_PRIV, cfg_data_t'({sie, p}));
  endtask

  task automatic clear_status();
    write_reg(`CLIC_ADDR_STATUS, '0);
  endtask

  function automatic src_mask_t src_bit(input int i);
    src_mask_t m;
    m = '0;
    m[i] = 1'b1;
    return m;
  endfunction

  // One-cycle high on the selected lines
  task automatic pulse(input src_mask_t mask);
    irq_src = mask;
    tick();
    irq_src = '0;
  endtask

  task automatic wait_req(output int n);
    n = 0;
    while (!irq_req) begin
      if (n >= REQ_WAIT) begin
        abort_run($sformatf("timeout, no interrupt request within %0d cycles", REQ_WAIT));
      end
      tick();
      n++;
    end
  endtask

  task automatic wait_cause(input irq_id_t id);
    int n;
    n = 0;
    while (!(irq_req && req_id == id)) begin
      if (n >= REQ_WAIT) begin
        abort_run($sformatf("timeout, no request from source %0d", id));
      end
      tick();
      n++;
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      assert (!irq_req) else report_mismatch("request although the threshold holds it back");
      tick();
    end
  endtask

  task automatic take(input irq_id_t id);
    assert (irq_req && req_id == id) else report_mismatch("no request from the ID to take");
    ack_id  = id;
    irq_ack = 1'b1;
    tick();
    irq_ack = 1'b0;
  endtask

  // Highest level wins, scanning down so equal levels go to the lower ID
  function automatic irq_id_t best_pending();
    irq_id_t    best;
    irq_level_t top;
    best = '0;
    top  = '0;
    for (int i = `CLIC_NUM_SRC - 1; i >= 0; i--) begin
      if (pend_m[i] && en_m[i] && lvl_m[i] >= top) begin
        best = irq_id_t'(i);
        top  = lvl_m[i];
      end
    end
    return best;
  endfunction

  // Take everything pending and enabled, best first
  task automatic drain();
    irq_id_t exp_id;
    int      n;
    while ((pend_m & en_m) != '0) begin
      exp_id = best_pending();
      wait_req(n);
      assert (req_id == exp_id) else report_mismatch("drain order is not by level and ID");
      take(exp_id);
      clear_status();  // mil back to 0 for the next one
    end
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic selection_rounds();
    src_mask_t  en_mask, pulse_mask;
    irq_level_t lvl;
    irq_id_t    exp_id;
    int         k, n;
    for (int r = 0; r < ROUNDS; r++) begin
      en_mask    = src_mask_t'($random(seed));
      pulse_mask = src_mask_t'($random(seed));
      k = {$random(seed)} % `CLIC_NUM_SRC;
      en_mask[k]    = 1'b1;  // at least one live candidate
      pulse_mask[k] = 1'b1;
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        // Odd rounds use few levels so ties show up
        lvl = (r % 2 == 0) ? irq_level_t'($random(seed)) : irq_level_t'({$random(seed)} % 4);
        if (lvl == '0) lvl = irq_level_t'(1);
        cfg_src(irq_id_t'(i), en_mask[i], PRIV_M, lvl);
      end
      pulse(pulse_mask);
      exp_id = best_pending();
      wait_req(n);
      assert (n == 1) else report_mismatch("request not 2 cycles after the source edge");
      assert (req_id == exp_id) else report_mismatch("winner is not highest level, lowest ID");
      drain();
      // Disabled pending sources join now
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        if (pend_m[i] && !en_m[i]) cfg_src(irq_id_t'(i), 1'b1, PRIV_M, lvl_m[i]);
      end
      idle(8);  // let preemption between them settle
      drain();
    end
  endtask

  task automatic m_threshold_test();
    int n;
    cfg_src(0, 1'b1, PRIV_M, 8'h40);
    cfg_src(1, 1'b1, PRIV_M, 8'h20);
    cfg_src(2, 1'b1, PRIV_M, 8'h40);
    write_reg(`CLIC_ADDR_MTHRESH, 16'h0030);
    pulse(src_bit(0));
    wait_req(n);
    assert (n == 1 && req_id == 0) else report_mismatch("source 0 not requested after 2 cycles");
    take(0);
    clear_status();
    expect_quiet(4);  // taken source stays quiet
    pulse(src_bit(1));  // below mthresh
    expect_quiet(6);
    write_reg(`CLIC_ADDR_MTHRESH, 16'h0010);
    wait_cause(1);
    take(1);
    write_reg(`CLIC_ADDR_MTHRESH, 16'h0000);
    clear_status();
    pulse(src_bit(0));
    wait_cause(0);
    take(0);  // mil now 0x40
    pulse(src_bit(2));  // equal to mil
    expect_quiet(6);
    clear_status();
    wait_cause(2);
    take(2);
    clear_status();
  endtask

  task automatic s_u_mode_test();
    int n;
    cfg_src(3, 1'b1, PRIV_S, 8'h50);
    cfg_src(4, 1'b1, PRIV_M, 8'h70);
    cfg_src(5, 1'b1, PRIV_U, 8'h05);
    set_priv(PRIV_S, 1'b0);
    pulse(src_bit(3));
    expect_quiet(6);  // sie off
    set_priv(PRIV_S, 1'b1);
    wait_cause(3);
    take(3);  // sil 0x50, sie cleared
    write_reg(`CLIC_ADDR_STHRESH, 16'h0060);
    write_reg(`CLIC_ADDR_MTHRESH, 16'h00ff);
    set_priv(PRIV_S, 1'b1);
    clear_status();  // only sthresh left to hold S back
    pulse(src_bit(3));
    expect_quiet(6);  // below sthresh
    pulse(src_bit(4));  // M beats S mode whatever mthresh says
    wait_cause(4);
    take(4);
    write_reg(`CLIC_ADDR_MTHRESH, 16'h0000);
    write_reg(`CLIC_ADDR_STHRESH, 16'h0000);
    set_priv(PRIV_U, 1'b0);
    wait_cause(3);  // U mode accepts the held S source
    take(3);
    set_priv(PRIV_U, 1'b0);
    clear_status();
    pulse(src_bit(5));
    wait_req(n);
    assert (n == 1 && req_id == 5) else report_mismatch("U source not requested in U mode");
    take(5);
    set_priv(PRIV_M, 1'b0);
    clear_status();
  endtask

  task automatic preemption_test();
    int n;
    cfg_src(6, 1'b1, PRIV_M, 8'h10);
    cfg_src(7, 1'b1, PRIV_M, 8'h90);
    pulse(src_bit(6));
    wait_req(n);
    assert (req_id == 6) else report_mismatch("low-level source 6 not offered");
    idle(3);
    assert (irq_req && req_id == 6) else report_mismatch("unacked request was dropped");
    pulse(src_bit(7));
    wait_cause(7);  // replaced with no acknowledge
    take(7);
    clear_status();
    wait_cause(6);  // still pending underneath
    take(6);
    clear_status();
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    irq_src   = '0;
    irq_ack   = 1'b0;
    ack_id    = '0;
    seed      = 32'hbfcae7e7;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    assert (!irq_req) else report_mismatch("request out of reset");
    selection_rounds();
    m_threshold_test();
    s_u_mode_test();
    preemption_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- clic_top.sv
// CLIC top level
// Register block, arbiter and core-side controller for eight
// edge-triggered sources. The core acknowledge arrives as a strobe.

`include "clic_params.svh"

module clic_top
  import priv_pkg::*;
  import clic_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // Configuration writes
  input  logic                     cfg_we_i,
  input  cfg_addr_t                cfg_addr_i,
  input  cfg_data_t                cfg_wdata_i,
  // Sources and core
  input  logic [`CLIC_NUM_SRC-1:0] irq_src_i,
  input  logic                     irq_ack_i,
  output logic                     irq_req_o,
  output irq_cause_t               irq_cause_o
);

  // Source table
  logic       [`CLIC_NUM_SRC-1:0] src_en;
  irq_level_t [`CLIC_NUM_SRC-1:0] src_level;
  priv_lvl_e  [`CLIC_NUM_SRC-1:0] src_priv;

  // Core-side state
  priv_lvl_e  priv_lvl;
  irq_level_t mthresh, sthresh, mil, sil;
  logic       sie;

  // Offer and kill handshake
  logic       irq_valid;
  irq_id_t    irq_id;
  irq_level_t irq_level;
  priv_lvl_e  irq_priv;
  logic       kill_req, kill_ack;

  // ----------------------------------------------------------
  // Register block, take info from the current offer
  // ----------------------------------------------------------
  clic_cfg_regs i_cfg_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .irq_take_i  (irq_ack_i),
    .take_level_i(irq_level),
    .take_priv_i (irq_priv),
    .src_en_o    (src_en),
    .src_level_o (src_level),
    .src_priv_o  (src_priv),
    .priv_lvl_o  (priv_lvl),
    .mthresh_o   (mthresh),
    .sthresh_o   (sthresh),
    .mil_o       (mil),
    .sil_o       (sil),
    .sie_o       (sie)
  );

  clic_arbiter i_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .irq_src_i  (irq_src_i),
    .src_en_i   (src_en),
    .src_level_i(src_level),
    .src_priv_i (src_priv),
    .irq_ack_i  (irq_ack_i),
    .kill_ack_i (kill_ack),
    .irq_valid_o(irq_valid),
    .irq_id_o   (irq_id),
    .irq_level_o(irq_level),
    .irq_priv_o (irq_priv),
    .kill_req_o (kill_req)
  );

  clic_irq_ctrl i_irq_ctrl (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .priv_lvl_i      (priv_lvl),
    .sie_i           (sie),
    .mthresh_i       (mthresh),
    .sthresh_i       (sthresh),
    .mil_i           (mil),
    .sil_i           (sil),
    .clic_irq_valid_i(irq_valid),
    .clic_irq_ready_i(irq_ack_i),  // core ack closes the request
    .clic_irq_id_i   (irq_id),
    .clic_irq_level_i(irq_level),
    .clic_irq_priv_i (irq_priv),
    .clic_kill_req_i (kill_req),
    .clic_kill_ack_o (kill_ack),
    .clic_irq_req_o  (irq_req_o),
    .clic_irq_cause_o(irq_cause_o)
  );

endmodule

//--- clic_irq_ctrl.sv
// CLIC core-side controller
// Checks the offered interrupt against privilege and thresholds, packs the
// cause word and grants kill requests while nothing is in flight.

`include "clic_params.svh"

module clic_irq_ctrl
  import priv_pkg::*;
  import clic_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Core-side state
  input  priv_lvl_e  priv_lvl_i,   // current privilege
  input  logic       sie_i,        // supervisor irq enable
  input  irq_level_t mthresh_i,
  input  irq_level_t sthresh_i,
  input  irq_level_t mil_i,        // status M level
  input  irq_level_t sil_i,        // status S level
  // From/to arbiter
  input  logic       clic_irq_valid_i,
  input  logic       clic_irq_ready_i,  // core took the irq
  input  irq_id_t    clic_irq_id_i,
  input  irq_level_t clic_irq_level_i,
  input  priv_lvl_e  clic_irq_priv_i,
  input  logic       clic_kill_req_i,
  output logic       clic_kill_ack_o,
  // To core
  output logic       clic_irq_req_o,
  output irq_cause_t clic_irq_cause_o
);

  // ----------------------------------------------------------
  // Acceptance
  // ----------------------------------------------------------
  irq_level_t eff_mthresh, eff_sthresh;  // max of threshold and status level
  logic       accept;

  assign eff_mthresh = (mthresh_i > mil_i) ? mthresh_i : mil_i;
  assign eff_sthresh = (sthresh_i > sil_i) ? sthresh_i : sil_i;

  always_comb begin
    accept = 1'b0;
    case (priv_lvl_i)
      PRIV_M: begin
        // Only M irqs above the M threshold
        if (clic_irq_priv_i == PRIV_M) begin
          accept = clic_irq_valid_i && (clic_irq_level_i > eff_mthresh);
        end
      end
      PRIV_S: begin
        if (clic_irq_priv_i == PRIV_M) begin
          accept = clic_irq_valid_i;  // M always preempts S
        end else if (clic_irq_priv_i == PRIV_S) begin
          accept = clic_irq_valid_i && sie_i && (clic_irq_level_i > eff_sthresh);
        end
      end
      PRIV_U:  accept = clic_irq_valid_i;  // anything goes
      default: ;  // reserved encoding
    endcase
  end

  // Withdrawn while the arbiter wants to swap the offer
  assign clic_irq_req_o = accept & ~clic_kill_req_i;

  // Cause word: irq flag, level for the status update, ID for mcause
  assign clic_irq_cause_o = {
    1'b1,
    {(`CLIC_XLEN - 25){1'b0}},
    clic_irq_level_i,
    {(16 - `CLIC_ID_W){1'b0}},
    clic_irq_id_i
  };

  // ----------------------------------------------------------
  // Kill control
  // ----------------------------------------------------------
  // Core may take a request up to one cycle after seeing it
  logic irq_inflight_d, irq_inflight_q;

  assign irq_inflight_d  = clic_irq_req_o & ~clic_irq_ready_i;
  assign clic_kill_ack_o = clic_kill_req_i & ~irq_inflight_q & ~clic_irq_req_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_inflight_q <= 1'b0;
    end else begin
      irq_inflight_q <= irq_inflight_d;
    end
  end

endmodule

//--- clic_arbiter.sv
// CLIC arbiter
// Latches rising source edges as pending, picks the enabled pending source
// with the highest level (lowest ID on ties) and holds it in an offer
// register. Requests a kill when a better source shows up.

`include "clic_params.svh"

module clic_arbiter
  import priv_pkg::*;
  import clic_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic       [`CLIC_NUM_SRC-1:0] irq_src_i,    // raw source lines
  // Source table
  input  logic       [`CLIC_NUM_SRC-1:0] src_en_i,
  input  irq_level_t [`CLIC_NUM_SRC-1:0] src_level_i,
  input  priv_lvl_e  [`CLIC_NUM_SRC-1:0] src_priv_i,
  // From core and controller
  input  logic                           irq_ack_i,    // offer taken
  input  logic                           kill_ack_i,   // offer may be replaced
  // Offer to controller
  output logic                           irq_valid_o,
  output irq_id_t                        irq_id_o,
  output irq_level_t                     irq_level_o,
  output priv_lvl_e                      irq_priv_o,
  output logic                           kill_req_o
);

  // ----------------------------------------------------------
  // Edge detect and pending bits
  // ----------------------------------------------------------
  logic [`CLIC_NUM_SRC-1:0] src_q;      // previous source levels
  logic [`CLIC_NUM_SRC-1:0] src_edge;
  logic [`CLIC_NUM_SRC-1:0] pend_q;
  logic [`CLIC_NUM_SRC-1:0] ack_clr;    // one-hot of taken ID

  // Offer register
  logic       offer_valid_q;
  irq_id_t    offer_id_q;
  irq_level_t offer_level_q;
  priv_lvl_e  offer_priv_q;
  logic       kill_q;

  assign src_edge = irq_src_i & ~src_q;

  always_comb begin
    ack_clr = '0;
    if (irq_ack_i) begin
      ack_clr[offer_id_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q  <= '0;
      pend_q <= '0;
    end else begin
      src_q  <= irq_src_i;
      pend_q <= (pend_q & ~ack_clr) | src_edge;  // fresh edge beats the clear
    end
  end

  // ----------------------------------------------------------
  // Winner scan
  // ----------------------------------------------------------
  logic [`CLIC_NUM_SRC-1:0] cand;
  logic       best_found;
  irq_id_t    best_id;
  irq_level_t best_level;

  assign cand = pend_q & src_en_i;

  // Strict compare keeps the lower ID on equal levels
  always_comb begin
    best_found = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (cand[i] && (!best_found || (src_level_i[i] > best_level))) begin
        best_found = 1'b1;
        best_id    = irq_id_t'(i);
        best_level = src_level_i[i];
      end
    end
  end

  // ----------------------------------------------------------
  // Offer register and kill request
  // ----------------------------------------------------------
  logic load;     // offer takes the current winner
  logic preempt;  // strictly better source than the offer

  assign load    = ~irq_ack_i & best_found & (~offer_valid_q | kill_ack_i);
  assign preempt = offer_valid_q & best_found & (best_id != offer_id_q)
                 & (best_level > offer_level_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      offer_valid_q <= 1'b0;
      kill_q        <= 1'b0;
    end else if (irq_ack_i) begin
      offer_valid_q <= 1'b0;  // taken, reload next cycle
      kill_q        <= 1'b0;
    end else if (kill_ack_i) begin
      offer_valid_q <= best_found;  // swap in the winner
      kill_q        <= 1'b0;
    end else if (!offer_valid_q) begin
      offer_valid_q <= best_found;
    end else if (preempt) begin
      kill_q <= 1'b1;  // held until kill_ack or take
    end
  end

  // Offer payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      offer_id_q    <= best_id;
      offer_level_q <= best_level;
      offer_priv_q  <= src_priv_i[best_id];
    end
  end

  assign irq_valid_o = offer_valid_q;
  assign irq_id_o    = offer_id_q;
  assign irq_level_o = offer_level_q;
  assign irq_priv_o  = offer_priv_q;
  assign kill_req_o  = kill_q;

endmodule

//--- clic_cfg_regs.sv
// CLIC register block
// Per-source enable, level and privilege table, plus the core-side
// privilege, thresholds, interrupt status and supervisor enable.
// Taking an interrupt updates privilege and status.

`include "clic_params.svh"

module clic_cfg_regs
  import priv_pkg::*;
  import clic_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Write port
  input  logic                           cfg_we_i,
  input  cfg_addr_t                      cfg_addr_i,
  input  cfg_data_t                      cfg_wdata_i,
  // Interrupt taken by the core
  input  logic                           irq_take_i,
  input  irq_level_t                     take_level_i,
  input  priv_lvl_e                      take_priv_i,
  // Source table to arbiter
  output logic       [`CLIC_NUM_SRC-1:0] src_en_o,
  output irq_level_t [`CLIC_NUM_SRC-1:0] src_level_o,
  output priv_lvl_e  [`CLIC_NUM_SRC-1:0] src_priv_o,
  // Core-side state to controller
  output priv_lvl_e                      priv_lvl_o,
  output irq_level_t                     mthresh_o,
  output irq_level_t                     sthresh_o,
  output irq_level_t                     mil_o,
  output irq_level_t                     sil_o,
  output logic                           sie_o
);

  logic       [`CLIC_NUM_SRC-1:0] src_en_q;
  irq_level_t [`CLIC_NUM_SRC-1:0] src_level_q;
  priv_lvl_e  [`CLIC_NUM_SRC-1:0] src_priv_q;

  priv_lvl_e  priv_q;
  irq_level_t mthresh_q, sthresh_q;
  intstatus_t status_q;
  logic       sie_q;

  logic    src_sel;  // address hits the source table
  irq_id_t src_idx;

  assign src_sel = cfg_addr_i < cfg_addr_t'(`CLIC_NUM_SRC);
  assign src_idx = cfg_addr_i[`CLIC_ID_W-1:0];

  // ----------------------------------------------------------
  // Source table
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_en_q <= '0;  // all sources off
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        src_level_q[i] <= '0;
        src_priv_q[i]  <= PRIV_U;
      end
    end else if (cfg_we_i && src_sel) begin
      src_level_q[src_idx] <= cfg_wdata_i[`CLIC_LEVEL_W-1:0];
      src_priv_q[src_idx]  <= priv_lvl_e'(cfg_wdata_i[`CLIC_SRC_PRIV_LSB +: $bits(priv_lvl_e)]);
      src_en_q[src_idx]    <= cfg_wdata_i[`CLIC_SRC_EN_BIT];
    end
  end

  // ----------------------------------------------------------
  // Core-side registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      priv_q    <= PRIV_M;  // out of reset in machine mode
      mthresh_q <= '0;
      sthresh_q <= '0;
      status_q  <= '0;
      sie_q     <= 1'b0;
    end else begin
      // Software writes
      if (cfg_we_i) begin
        case (cfg_addr_i)
          cfg_addr_t'(`CLIC_ADDR_MTHRESH): mthresh_q <= cfg_wdata_i[`CLIC_LEVEL_W-1:0];
          cfg_addr_t'(`CLIC_ADDR_STHRESH): sthresh_q <= cfg_wdata_i[`CLIC_LEVEL_W-1:0];
          cfg_addr_t'(`CLIC_ADDR_STATUS):  status_q  <= cfg_wdata_i;
          cfg_addr_t'(`CLIC_ADDR_PRIV): begin
            priv_q <= priv_lvl_e'(cfg_wdata_i[$bits(priv_lvl_e)-1:0]);
            sie_q  <= cfg_wdata_i[`CLIC_SIE_BIT];
          end
          default: ;  // source table or unmapped
        endcase
      end
      // Interrupt take, overrides a write in the same cycle
      if (irq_take_i) begin
        priv_q <= take_priv_i;
        if (take_priv_i == PRIV_M) begin
          status_q <= status_set_mil(status_q, take_level_i);
        end else if (take_priv_i == PRIV_S) begin
          status_q <= status_set_sil(status_q, take_level_i);
          sie_q    <= 1'b0;  // no nesting until software re-enables
        end
      end
    end
  end

  // Outputs
  assign src_en_o    = src_en_q;
  assign src_level_o = src_level_q;
  assign src_priv_o  = src_priv_q;
  assign priv_lvl_o  = priv_q;
  assign mthresh_o   = mthresh_q;
  assign sthresh_o   = sthresh_q;
  assign mil_o       = status_mil(status_q);
  assign sil_o       = status_sil(status_q);
  assign sie_o       = sie_q;

endmodule

//--- clic_pkg.sv
// CLIC data types
// Widths of interrupt IDs, levels, the cause word and the config port

`include "clic_params.svh"

package clic_pkg;

  // ----------------------------------------------------------
  // Interrupt side
  // ----------------------------------------------------------
  typedef logic [`CLIC_ID_W-1:0]    irq_id_t;     // source index
  typedef logic [`CLIC_LEVEL_W-1:0] irq_level_t;  // higher wins
  typedef logic [`CLIC_XLEN-1:0]    irq_cause_t;  // packed cause to core

  // ----------------------------------------------------------
  // Configuration port
  // ----------------------------------------------------------
  // Write address, 0..7 source table, 16..19 core-side registers
  typedef logic [`CLIC_ADDR_W-1:0]  cfg_addr_t;

  // Write data, layout depends on the address
  //   source entry   en[10] priv[9:8] level[7:0]
  //   status         sil[15:8] mil[7:0]
  //   privilege      sie[2] priv[1:0]
  //   thresholds     level[7:0]
  typedef logic [`CLIC_DATA_W-1:0]  cfg_data_t;

endpackage

//--- priv_pkg.sv
// Privilege definitions for the CLIC core side
// Privilege encoding and helpers for the interrupt-status register

`include "clic_params.svh"

package priv_pkg;

  // RISC-V privilege encoding, 2'b10 reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Interrupt status word, M level low, S level high
  typedef logic [2*`CLIC_LEVEL_W-1:0] intstatus_t;

  function automatic logic [`CLIC_LEVEL_W-1:0] status_mil(intstatus_t st);
    return st[`CLIC_LEVEL_W-1:0];
  endfunction

  function automatic logic [`CLIC_LEVEL_W-1:0] status_sil(intstatus_t st);
    return st[2*`CLIC_LEVEL_W-1:`CLIC_LEVEL_W];
  endfunction

  // Replace one field, keep the other
  function automatic intstatus_t status_set_mil(intstatus_t st, logic [`CLIC_LEVEL_W-1:0] lvl);
    return {st[2*`CLIC_LEVEL_W-1:`CLIC_LEVEL_W], lvl};
  endfunction

  function automatic intstatus_t status_set_sil(intstatus_t st, logic [`CLIC_LEVEL_W-1:0] lvl);
    return {lvl, st[`CLIC_LEVEL_W-1:0]};
  endfunction

endpackage

//--- clic_params.svh
// CLIC global parameters
// Source count, field widths and register map of the configuration port

`ifndef CLIC_PARAMS_SVH
`define CLIC_PARAMS_SVH

// Interrupt sources
`define CLIC_NUM_SRC       8
`define CLIC_ID_W          3   // log2 of source count
`define CLIC_LEVEL_W       8
`define CLIC_XLEN          32  // cause word width

// Configuration write port
`define CLIC_ADDR_W        5
`define CLIC_DATA_W        16

// Register map, addresses 0..7 are the per-source entries
`define CLIC_ADDR_MTHRESH  16
`define CLIC_ADDR_STHRESH  17
`define CLIC_ADDR_STATUS   18
`define CLIC_ADDR_PRIV     19

// Field positions inside write data
`define CLIC_SRC_PRIV_LSB  8   // per-source privilege, 2 bits
`define CLIC_SRC_EN_BIT    10  // per-source enable
`define CLIC_SIE_BIT       2   // in privilege register

`endif
